/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // register word and the two opcode fields
    typedef logic [31:0] word_t;
    typedef logic [2:0]  func3_t;
    typedef logic [6:0]  func7_t;

    // major opcodes, one per unit group
    localparam func7_t FUNC7_FADD  = 7'b0000000;
    localparam func7_t FUNC7_FSUB  = 7'b0000100;
    localparam func7_t FUNC7_FSGNJ = 7'b0010000;
    localparam func7_t FUNC7_FCOMP = 7'b1010000;
    // float to int register move
    localparam func7_t FUNC7_FMVI  = 7'b1110000;
    // int to float register move
    localparam func7_t FUNC7_IMVF  = 7'b1111000;

    // sign injection selectors
    localparam func3_t FUNC3_FSGNJ  = 3'd0;
    localparam func3_t FUNC3_FSGNJN = 3'd1;
    localparam func3_t FUNC3_FSGNJX = 3'd2;

    // comparison selectors
    localparam func3_t FUNC3_FLE = 3'd0;
    localparam func3_t FUNC3_FLT = 3'd1;
    localparam func3_t FUNC3_FEQ = 3'd2;

endpackage

`default_nettype wire

/* source/float_pkg.sv */
`default_nettype none

package float_pkg;

    localparam int EXP_W = 8;
    localparam int MAN_W = 23;

    // carry, hidden one, fraction, then guard, round and sticky
    localparam int SIG_W = MAN_W + 5;

    typedef logic [EXP_W-1:0] fexp_t;
    typedef logic [MAN_W-1:0] fman_t;
    typedef logic [SIG_W-1:0] fsig_t;

    // all ones exponent, used as the overflow result
    localparam fexp_t EXP_MAX = '1;

    // ieee single layout, msb first
    typedef struct packed {
        logic  sign;
        fexp_t exp;
        fman_t man;
    } float_t;

    // adder pipeline contents
    typedef struct packed {
        // sign of the larger operand
        logic  sign;
        // exponent of the larger operand
        fexp_t exp;
        // aligned operand or sum, grs in the low three bits
        fsig_t sig;
        // both inputs were zero or flushed
        logic  zero;
    } add_stage_t;

endpackage

`default_nettype wire

/* source/fadd.sv */
`default_nettype none

module fadd
    import isa_pkg::*, float_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  order,
    output logic  accepted,
    output logic  done,
    input  word_t rs1,
    input  word_t rs2,
    output word_t rd
);

    // exponent math needs room for a borrow and a carry
    localparam int XW   = EXP_W + 2;
    localparam int LZ_W = $clog2(SIG_W);

    logic [2:0] valid;

    float_t     op_a;
    float_t     op_b;
    float_t     op_big;
    float_t     op_small;
    fsig_t      big_sig;
    fsig_t      small_sig;
    fsig_t      shifted;
    fexp_t      shift;
    logic       lost;

    add_stage_t s1_d;
    add_stage_t s1_q;
    fsig_t      big_q;
    logic       sub_d;
    logic       sub_q;
    add_stage_t s2_q;

    logic            carry;
    logic [LZ_W-1:0] lz;
    logic [SIG_W-2:0] norm;
    logic [MAN_W:0]  sig_n;
    logic            guard;
    logic            rnd;
    logic            sticky;
    logic            round_up;
    logic [MAN_W+1:0] rounded;
    logic [XW-1:0]   exp_calc;
    float_t          res;
    word_t           res_q;

    function automatic logic [LZ_W-1:0] lead_zeros(input logic [SIG_W-2:0] v);
        logic [LZ_W-1:0] n;
        logic            seen;
        n    = '0;
        seen = 1'b0;
        for (int i = SIG_W - 2; i >= 0; i--) begin
            if (v[i]) begin
                seen = 1'b1;
            end else if (!seen) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    // the fpu only orders when idle, so take it at once
    assign accepted = order;
    assign done     = valid[2];
    assign rd       = res_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            valid <= {valid[1:0], order};
        end
    end

    // stage 1 orders by magnitude and aligns the smaller operand
    always_comb begin
        op_a     = float_t'(rs1);
        op_b     = float_t'(rs2);
        op_big   = ({op_a.exp, op_a.man} >= {op_b.exp, op_b.man}) ? op_a : op_b;
        op_small = ({op_a.exp, op_a.man} >= {op_b.exp, op_b.man}) ? op_b : op_a;
        // denormals count as zero
        big_sig   = (op_big.exp != '0) ? {2'b01, op_big.man, 3'b000} : '0;
        small_sig = (op_small.exp != '0) ? {2'b01, op_small.man, 3'b000} : '0;
        shift     = op_big.exp - op_small.exp;
        if (shift >= fexp_t'(SIG_W)) begin
            shifted = '0;
            lost    = |small_sig;
        end else begin
            shifted = small_sig >> shift;
            lost    = |(small_sig & ((fsig_t'(1) << shift) - fsig_t'(1)));
        end
        s1_d.sign = op_big.sign;
        s1_d.exp  = op_big.exp;
        s1_d.sig  = {shifted[SIG_W-1:1], shifted[0] | lost};
        s1_d.zero = (op_big.exp == '0);
        sub_d     = op_a.sign ^ op_b.sign;
    end

    always_ff @(posedge clk) begin
        if (order) begin
            s1_q  <= s1_d;
            big_q <= big_sig;
            sub_q <= sub_d;
        end
    end

    // stage 2 takes the larger magnitude minus or plus the aligned one
    always_ff @(posedge clk) begin
        if (valid[0]) begin
            s2_q.sign <= s1_q.sign;
            s2_q.exp  <= s1_q.exp;
            s2_q.sig  <= sub_q ? big_q - s1_q.sig : big_q + s1_q.sig;
            s2_q.zero <= s1_q.zero;
        end
    end

    // stage 3 normalizes, rounds to nearest even and flushes small results
    always_comb begin
        carry = s2_q.sig[SIG_W-1];
        lz    = lead_zeros(s2_q.sig[SIG_W-2:0]);
        norm  = s2_q.sig[SIG_W-2:0] << lz;
        if (carry) begin
            sig_n  = s2_q.sig[SIG_W-1:4];
            guard  = s2_q.sig[3];
            rnd    = s2_q.sig[2];
            sticky = |s2_q.sig[1:0];
        end else begin
            sig_n  = norm[SIG_W-2:3];
            guard  = norm[2];
            rnd    = norm[1];
            sticky = norm[0];
        end
        round_up = guard & (rnd | sticky | sig_n[0]);
        rounded  = {1'b0, sig_n} + (MAN_W + 2)'(round_up);
        // rounding can carry into a new leading one
        exp_calc = XW'(s2_q.exp) + XW'(carry) + XW'(rounded[MAN_W+1])
                 - (carry ? XW'(0) : XW'(lz));

        res.sign = s2_q.sign;
        res.exp  = exp_calc[EXP_W-1:0];
        res.man  = rounded[MAN_W-1:0];
        if (s2_q.zero || s2_q.sig == '0 || exp_calc[XW-1] || exp_calc == '0) begin
            // exact cancellation and underflow both give +0
            res = '0;
        end else if (exp_calc >= XW'(EXP_MAX)) begin
            res.exp = EXP_MAX;
            res.man = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (valid[1]) begin
            res_q <= word_t'(res);
        end
    end

    // done belongs to a lone order with nothing entered behind it
    a_done_after_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> $past(order, 3) && !$past(order, 2) && !$past(order, 1));

    // one item at a time in the pipeline
    a_accept_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) accepted |-> order && valid == '0);

endmodule

`default_nettype wire

/* source/fmisc.sv */
`default_nettype none

module fmisc
    import isa_pkg::*, float_pkg::*;
(
    input  logic   order,
    output logic   accepted,
    output logic   done,
    input  func7_t func7,
    input  func3_t func3,
    input  word_t  rs1,
    input  word_t  rs2,
    output word_t  rd
);

    float_t op_a;
    float_t op_b;
    logic   both_zero;
    logic   is_eq;
    logic   is_lt;
    float_t sgn_res;

    // single cycle, so every order finishes where it starts
    assign accepted = order;
    assign done     = order;

    // sign-magnitude compare
    always_comb begin
        op_a      = float_t'(rs1);
        op_b      = float_t'(rs2);
        // -0 and +0 are the same value
        both_zero = ({op_a.exp, op_a.man} == '0) && ({op_b.exp, op_b.man} == '0);
        is_eq     = (rs1 == rs2) || both_zero;
        if (both_zero) begin
            is_lt = 1'b0;
        end else if (op_a.sign != op_b.sign) begin
            is_lt = op_a.sign;
        end else if (op_a.sign) begin
            // both negative, larger magnitude is smaller
            is_lt = {op_a.exp, op_a.man} > {op_b.exp, op_b.man};
        end else begin
            is_lt = {op_a.exp, op_a.man} < {op_b.exp, op_b.man};
        end
    end

    // rs1 magnitude with a new sign
    always_comb begin
        sgn_res = op_a;
        case (func3)
            FUNC3_FSGNJ:  sgn_res.sign = op_b.sign;
            FUNC3_FSGNJN: sgn_res.sign = ~op_b.sign;
            FUNC3_FSGNJX: sgn_res.sign = op_a.sign ^ op_b.sign;
            default:      sgn_res      = '0;
        endcase
    end

    always_comb begin
        rd = '0;
        case (func7)
            FUNC7_FSGNJ: begin
                rd = word_t'(sgn_res);
            end
            FUNC7_FCOMP: begin
                case (func3)
                    FUNC3_FLE: rd = word_t'(is_lt | is_eq);
                    FUNC3_FLT: rd = word_t'(is_lt);
                    FUNC3_FEQ: rd = word_t'(is_eq);
                    default:   rd = '0;
                endcase
            end
            // raw bit moves between register files
            FUNC7_FMVI, FUNC7_IMVF: begin
                rd = rs1;
            end
            default: begin
                rd = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/fpu.sv */
`default_nettype none

module fpu
    import isa_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   order,
    output logic   accepted,
    output logic   done,
    input  func3_t func3,
    input  func7_t func7,
    input  word_t  rs1,
    input  word_t  rs2,
    output word_t  rd
);

    logic  busy;
    logic  order_able;
    logic  is_add;
    logic  is_misc;

    logic  fadd_order;
    logic  fadd_accepted;
    logic  fadd_done;
    word_t fadd_rs2;
    word_t fadd_rd;

    logic  misc_order;
    logic  misc_accepted;
    logic  misc_done;
    word_t misc_rd;

    // unknown opcode, answered here
    logic  err_order;

    // a unit is working from the cycle after acceptance until done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (done) begin
            busy <= 1'b0;
        end else if (accepted) begin
            busy <= 1'b1;
        end
    end

    assign order_able = order & ~busy;

    always_comb begin
        is_add  = 1'b0;
        is_misc = 1'b0;
        case (func7)
            FUNC7_FADD, FUNC7_FSUB: begin
                is_add = 1'b1;
            end
            FUNC7_FSGNJ, FUNC7_FCOMP, FUNC7_FMVI, FUNC7_IMVF: begin
                is_misc = 1'b1;
            end
            default: begin
                is_add  = 1'b0;
                is_misc = 1'b0;
            end
        endcase
    end

    assign fadd_order = order_able & is_add;
    assign misc_order = order_able & is_misc;
    assign err_order  = order_able & ~is_add & ~is_misc;

    // subtract is an add with rs2 negated
    assign fadd_rs2 = (func7 == FUNC7_FSUB) ? {~rs2[31], rs2[30:0]} : rs2;

    fadd u_fadd (
        .clk      (clk),
        .rst_n    (rst_n),
        .order    (fadd_order),
        .accepted (fadd_accepted),
        .done     (fadd_done),
        .rs1      (rs1),
        .rs2      (fadd_rs2),
        .rd       (fadd_rd)
    );

    fmisc u_fmisc (
        .order    (misc_order),
        .accepted (misc_accepted),
        .done     (misc_done),
        .func7    (func7),
        .func3    (func3),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (misc_rd)
    );

    assign accepted = fadd_accepted | misc_accepted | err_order;
    assign done     = fadd_done | misc_done | err_order;

    // latch the finishing unit's word, held until the next done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd <= '0;
        end else if (done) begin
            if (fadd_done) begin
                rd <= fadd_rd;
            end else if (misc_done) begin
                rd <= misc_rd;
            end else begin
                rd <= '0;
            end
        end
    end

    a_one_done_source: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0({fadd_done, misc_done, err_order}));

    a_no_accept_busy: assert property (
        @(posedge clk) disable iff (!rst_n) accepted |-> !busy);

endmodule

`default_nettype wire

/* tb/fpu_checker.sv */
`default_nettype none

module fpu_checker
    import isa_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       order,
    input  logic       accepted,
    input  logic       done,
    input  word_t      rd,
    input  word_t      expected,
    input  logic [3:0] exp_lat,
    output int         checks,
    output int         value_errors,
    output int         proto_errors
);

    // longest wait for done on a held order
    localparam int MAX_WAIT = 8;

    logic       done_q;
    logic       in_flight;
    logic [3:0] since_acc;
    int         wait_cycles;
    int         bad;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q       <= 1'b0;
            in_flight    <= 1'b0;
            since_acc    <= '0;
            wait_cycles  <= 0;
            checks       <= 0;
            value_errors <= 0;
            proto_errors <= 0;
        end else begin
            bad    = 0;
            done_q <= done;
            // rd is loaded at the edge that ends the done cycle
            if (done_q) begin
                checks <= checks + 1;
                if (rd !== expected) begin
                    $display("FAIL %0t: rd is %08h, expected %08h", $time, rd, expected);
                    value_errors <= value_errors + 1;
                end
            end
            if (done && !order) begin
                $display("at %0t the fpu signalled done with no order pending", $time);
                bad++;
            end
            if (accepted && in_flight) begin
                $display("at %0t an order was accepted while the fadd was still busy", $time);
                bad++;
            end
            if (accepted) begin
                since_acc <= 4'd1;
                in_flight <= !done;
                if (done && exp_lat != 4'd0) begin
                    $display("at %0t done came with accepted, expected it %0d cycles later",
                             $time, exp_lat);
                    bad++;
                end
            end else if (in_flight && done) begin
                in_flight <= 1'b0;
                if (since_acc != exp_lat) begin
                    $display("at %0t done came %0d cycles after accepted, expected %0d",
                             $time, since_acc, exp_lat);
                    bad++;
                end
            end else if (in_flight) begin
                since_acc <= since_acc + 4'd1;
            end
            // a held order must see done within a few cycles
            if (order && !done) begin
                wait_cycles <= wait_cycles + 1;
                if (wait_cycles == MAX_WAIT) begin
                    $display("at %0t no done arrived within %0d cycles of the order",
                             $time, MAX_WAIT);
                    bad++;
                end
            end else begin
                wait_cycles <= 0;
            end
            proto_errors <= proto_errors + bad;
        end
    end

endmodule

`default_nettype wire

/* tb/tb_fpu.sv */
`default_nettype none

module tb_fpu
    import isa_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int NUM_ROWS    = 20;
    localparam int NUM_RAND    = 40;

    // one directed operation and its result
    typedef struct packed {
        func7_t f7;
        func3_t f3;
        word_t  a;
        word_t  b;
        word_t  want;
    } row_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       order;
    logic       accepted;
    logic       done;
    func3_t     func3;
    func7_t     func7;
    word_t      rs1;
    word_t      rs2;
    word_t      rd;
    word_t      expected;
    logic [3:0] exp_lat;
    int         checks;
    int         value_errors;
    int         proto_errors;
    row_t       rows [NUM_ROWS];

    always #(CLK_PERIOD / 2) clk = ~clk;

    fpu u_fpu (
        .clk      (clk),
        .rst_n    (rst_n),
        .order    (order),
        .accepted (accepted),
        .done     (done),
        .func3    (func3),
        .func7    (func7),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd)
    );

    fpu_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .order        (order),
        .accepted     (accepted),
        .done         (done),
        .rd           (rd),
        .expected     (expected),
        .exp_lat      (exp_lat),
        .checks       (checks),
        .value_errors (value_errors),
        .proto_errors (proto_errors)
    );

    // adds take three cycles, everything else finishes at once
    function automatic logic [3:0] latency_for(input func7_t f7);
        return (f7 == FUNC7_FADD || f7 == FUNC7_FSUB) ? 4'd3 : 4'd0;
    endfunction

    function automatic word_t misc_result(input func7_t f7, input func3_t f3,
                                          input word_t a, input word_t b);
        logic signed [32:0] ka;
        logic signed [32:0] kb;
        word_t              r;
        // signed keys, -0 and +0 both land on zero
        ka = a[31] ? -$signed({2'b00, a[30:0]}) : $signed({2'b00, a[30:0]});
        kb = b[31] ? -$signed({2'b00, b[30:0]}) : $signed({2'b00, b[30:0]});
        r  = '0;
        if (f7 == FUNC7_FSGNJ) begin
            case (f3)
                FUNC3_FSGNJ:  r = {b[31], a[30:0]};
                FUNC3_FSGNJN: r = {~b[31], a[30:0]};
                FUNC3_FSGNJX: r = {a[31] ^ b[31], a[30:0]};
                default:      r = '0;
            endcase
        end else if (f7 == FUNC7_FCOMP) begin
            case (f3)
                FUNC3_FLE: r = {31'd0, ka <= kb};
                FUNC3_FLT: r = {31'd0, ka < kb};
                FUNC3_FEQ: r = {31'd0, ka == kb};
                default:   r = '0;
            endcase
        end
        return r;
    endfunction

    // sums worked out by hand
    task automatic load_rows();
        rows[0]  = '{FUNC7_FADD, 3'd0, 32'h3F80_0000, 32'h4000_0000, 32'h4040_0000};
        rows[1]  = '{FUNC7_FADD, 3'd0, 32'h3FC0_0000, 32'h3FC0_0000, 32'h4040_0000};
        rows[2]  = '{FUNC7_FADD, 3'd0, 32'h4020_0000, 32'h3F00_0000, 32'h4040_0000};
        rows[3]  = '{FUNC7_FADD, 3'd0, 32'h4120_0000, 32'h3E80_0000, 32'h4124_0000};
        // halfway ties, one rounds down to even and one up
        rows[4]  = '{FUNC7_FADD, 3'd0, 32'h3F80_0000, 32'h3380_0000, 32'h3F80_0000};
        rows[5]  = '{FUNC7_FADD, 3'd0, 32'h3F80_0001, 32'h3380_0000, 32'h3F80_0002};
        rows[6]  = '{FUNC7_FADD, 3'd0, 32'hBF80_0000, 32'hC000_0000, 32'hC040_0000};
        rows[7]  = '{FUNC7_FADD, 3'd0, 32'h4040_0000, 32'hBF80_0000, 32'h4000_0000};
        rows[8]  = '{FUNC7_FSUB, 3'd0, 32'h4040_0000, 32'h3F80_0000, 32'h4000_0000};
        rows[9]  = '{FUNC7_FSUB, 3'd0, 32'h3F80_0000, 32'h4000_0000, 32'hBF80_0000};
        rows[10] = '{FUNC7_FSUB, 3'd0, 32'h4080_0000, 32'h3E80_0000, 32'h4070_0000};
        rows[11] = '{FUNC7_FSUB, 3'd0, 32'hBFC0_0000, 32'hBFC0_0000, 32'h0000_0000};
        // difference below the smallest normal
        rows[12] = '{FUNC7_FSUB, 3'd0, 32'h0080_0001, 32'h0080_0000, 32'h0000_0000};
        rows[13] = '{FUNC7_FSGNJ, FUNC3_FSGNJN, 32'h3F80_0000, 32'hC000_0000, 32'h3F80_0000};
        rows[14] = '{FUNC7_FCOMP, FUNC3_FLE, 32'h0000_0000, 32'h8000_0000, 32'h0000_0001};
        rows[15] = '{FUNC7_FCOMP, FUNC3_FLT, 32'h8000_0000, 32'h0000_0000, 32'h0000_0000};
        rows[16] = '{FUNC7_FCOMP, FUNC3_FEQ, 32'h8000_0000, 32'h0000_0000, 32'h0000_0001};
        rows[17] = '{FUNC7_FMVI, 3'd0, 32'h1234_5678, 32'h0000_0000, 32'h1234_5678};
        rows[18] = '{FUNC7_IMVF, 3'd0, 32'h89AB_CDEF, 32'h0000_0000, 32'h89AB_CDEF};
        rows[19] = '{7'h7F, 3'd0, 32'h3F80_0000, 32'h3F80_0000, 32'h0000_0000};
    endtask

    // hold the order until done, then one idle cycle for the rd check
    task automatic apply_op(input func7_t f7, input func3_t f3, input word_t a,
                            input word_t b, input word_t want);
        func7    = f7;
        func3    = f3;
        rs1      = a;
        rs2      = b;
        expected = want;
        exp_lat  = latency_for(f7);
        order    = 1'b1;
        do begin
            @(posedge clk);
        end while (!done);
        #DRIVE_DELAY;
        order = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    initial begin
        word_t  a;
        word_t  b;
        func7_t f7;
        func3_t f3;
        void'($urandom(39));
        rst_n    = 1'b0;
        order    = 1'b0;
        func3    = '0;
        func7    = '0;
        rs1      = '0;
        rs2      = '0;
        expected = '0;
        exp_lat  = '0;
        load_rows();
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_op(rows[i].f7, rows[i].f3, rows[i].a, rows[i].b, rows[i].want);
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            f7 = ($urandom % 2 == 0) ? FUNC7_FSGNJ : FUNC7_FCOMP;
            f3 = func3_t'($urandom % 4);
            a  = $urandom;
            b  = $urandom;
            if (i % 4 == 0) begin
                // zero magnitudes with either sign
                a = {a[31], 31'd0};
                b = {b[31], 31'd0};
            end else if (i % 4 == 1) begin
                b = {b[31], a[30:0]};
            end
            apply_op(f7, f3, a, b, misc_result(f7, f3, a, b));
        end
        $display("checks %0d, value errors %0d, protocol errors %0d",
                 checks, value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0 && checks == NUM_ROWS + NUM_RAND) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // no operation needs anywhere near 10 cycles
    initial begin
        #((NUM_ROWS + NUM_RAND) * 10 * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles",
                 (NUM_ROWS + NUM_RAND) * 10);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
source/isa_pkg.sv
source/float_pkg.sv
source/fadd.sv
source/fmisc.sv
source/fpu.sv
tb/fpu_checker.sv
tb/tb_fpu.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f list.f --top-module tb_fpu -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_fpu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF -- ">>> PASS"; then
    exit 0
fi
exit 1
